// File: hw/dlxIsaPkg.sv
package dlxIsaPkg;

	localparam int DataWidth = 32;
	localparam int RegAddrWidth = 5;
	localparam int NumRegs = 32;
	localparam int InstrWidth = 32;
	localparam int OpcodeWidth = 6;
	localparam int ImmWidth = 16;
	localparam int ShamtWidth = 5;
	localparam int ExpWidth = 8;
	localparam int FracWidth = 23;

	// ====================================================================
	// Instruction fields, bit 0 is the leftmost bit.
	// ====================================================================
	localparam int OpcodeLo = 0;
	localparam int OpcodeHi = 5;
	localparam int Rs1Lo = 6;
	localparam int Rs1Hi = 10;
	localparam int Rs2Lo = 11;
	localparam int Rs2Hi = 15;
	localparam int RdRLo = 16;
	localparam int RdRHi = 20;
	localparam int RdILo = 11;
	localparam int RdIHi = 15;
	localparam int ImmLo = 16;
	localparam int ImmHi = 31;

	// Integer opcodes.
	localparam logic [0:OpcodeWidth-1] OpAdd = 6'h01;
	localparam logic [0:OpcodeWidth-1] OpSub = 6'h02;
	localparam logic [0:OpcodeWidth-1] OpAnd = 6'h03;
	localparam logic [0:OpcodeWidth-1] OpOr = 6'h04;
	localparam logic [0:OpcodeWidth-1] OpXor = 6'h05;
	localparam logic [0:OpcodeWidth-1] OpSlt = 6'h06;
	localparam logic [0:OpcodeWidth-1] OpSll = 6'h07;
	localparam logic [0:OpcodeWidth-1] OpSrl = 6'h08;
	localparam logic [0:OpcodeWidth-1] OpAddi = 6'h09;

	// Floating point opcodes.
	localparam logic [0:OpcodeWidth-1] OpFneg = 6'h10;
	localparam logic [0:OpcodeWidth-1] OpFabs = 6'h11;
	localparam logic [0:OpcodeWidth-1] OpFlt = 6'h12;
	localparam logic [0:OpcodeWidth-1] OpMovi2fp = 6'h13;
	localparam logic [0:OpcodeWidth-1] OpMovfp2i = 6'h14;

	// A register word seen as an integer or as an IEEE single.
	typedef union packed {
		logic [0:DataWidth-1] raw;
		struct packed {
			logic sign;
			logic [0:ExpWidth-1] exponent;
			logic [0:FracWidth-1] fraction;
		} fp;
	} dataWord_u;

endpackage

// File: hw/dlxCorePkg.sv
package dlxCorePkg;

	// Operation queue sizing.
	localparam int QueueDepth = 4;
	localparam int CreditWidth = $clog2(QueueDepth + 1);
	localparam int QueuePtrWidth = $clog2(QueueDepth);

	// ====================================================================
	// Execute operations
	// ====================================================================
	localparam int ExecOpWidth = 4;

	localparam logic [0:ExecOpWidth-1] ExAdd = 4'd0;
	localparam logic [0:ExecOpWidth-1] ExSub = 4'd1;
	localparam logic [0:ExecOpWidth-1] ExAnd = 4'd2;
	localparam logic [0:ExecOpWidth-1] ExOr = 4'd3;
	localparam logic [0:ExecOpWidth-1] ExXor = 4'd4;
	localparam logic [0:ExecOpWidth-1] ExSlt = 4'd5;
	localparam logic [0:ExecOpWidth-1] ExSll = 4'd6;
	localparam logic [0:ExecOpWidth-1] ExSrl = 4'd7;
	localparam logic [0:ExecOpWidth-1] ExFneg = 4'd8;
	localparam logic [0:ExecOpWidth-1] ExFabs = 4'd9;
	localparam logic [0:ExecOpWidth-1] ExFlt = 4'd10;
	// Plain copy of operand A, used by both register moves.
	localparam logic [0:ExecOpWidth-1] ExMove = 4'd11;

endpackage

// File: hw/regFile.sv
module regFile (
	input logic clk,
	input logic rst,
	input logic wrEn,
	input logic wrFp,
	input logic [0:dlxIsaPkg::RegAddrWidth-1] wrAddr,
	input logic [0:dlxIsaPkg::DataWidth-1] wrData,
	input logic rdFp,
	input logic [0:dlxIsaPkg::RegAddrWidth-1] rdAddr1,
	input logic [0:dlxIsaPkg::RegAddrWidth-1] rdAddr2,
	output logic [0:dlxIsaPkg::DataWidth-1] rdData1,
	output logic [0:dlxIsaPkg::DataWidth-1] rdData2
);

	import dlxIsaPkg::*;

	// Integer and floating point banks.
	logic [0:DataWidth-1] intBank [0:NumRegs-1];
	logic [0:DataWidth-1] fpBank [0:NumRegs-1];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NumRegs; i++) begin
				intBank[i] <= '0;
				fpBank[i] <= '0;
			end
		end else if (wrEn) begin
			if (wrFp)
				fpBank[wrAddr] <= wrData;
			else
				intBank[wrAddr] <= wrData;
		end
	end

	// Both ports read from the same bank.
	assign rdData1 = rdFp ? fpBank[rdAddr1] : intBank[rdAddr1];
	assign rdData2 = rdFp ? fpBank[rdAddr2] : intBank[rdAddr2];

endmodule

// File: hw/issueUnit.sv
module issueUnit (
	input logic clk,
	input logic rst,
	input logic instrValid,
	input logic [0:dlxIsaPkg::InstrWidth-1] instrWord,
	output logic instrReady,
	output logic rdFp,
	output logic [0:dlxIsaPkg::RegAddrWidth-1] rdAddr1,
	output logic [0:dlxIsaPkg::RegAddrWidth-1] rdAddr2,
	input logic [0:dlxIsaPkg::DataWidth-1] rdData1,
	input logic [0:dlxIsaPkg::DataWidth-1] rdData2,
	input logic creditReturn,
	input logic retireFire,
	input logic [0:dlxIsaPkg::RegAddrWidth-1] retireDest,
	input logic retireFp,
	output logic opValid,
	output logic [0:dlxCorePkg::ExecOpWidth-1] opExec,
	output logic [0:dlxIsaPkg::RegAddrWidth-1] opDest,
	output logic opDestFp,
	output logic [0:dlxIsaPkg::DataWidth-1] opA,
	output logic [0:dlxIsaPkg::DataWidth-1] opB
);

	import dlxIsaPkg::*;
	import dlxCorePkg::*;

	logic [0:OpcodeWidth-1] opcode;
	logic [0:RegAddrWidth-1] rs1;
	logic [0:RegAddrWidth-1] rs2;
	logic [0:RegAddrWidth-1] rd;
	logic [0:DataWidth-1] immExt;
	logic [0:ExecOpWidth-1] execOp;
	logic known;
	logic isImm;
	logic useRs2;
	logic readFp;
	logic destFp;
	logic [0:NumRegs-1] intBusy;
	logic [0:NumRegs-1] fpBusy;
	logic [0:CreditWidth-1] creditCnt;
	logic srcBusy;
	logic dstBusy;
	logic spend;

	// ====================================================================
	// Decode
	// ====================================================================
	assign opcode = instrWord[OpcodeLo:OpcodeHi];
	assign rs1 = instrWord[Rs1Lo:Rs1Hi];
	assign rs2 = instrWord[Rs2Lo:Rs2Hi];
	assign isImm = (opcode == OpAddi);
	assign rd = isImm ? instrWord[RdILo:RdIHi] : instrWord[RdRLo:RdRHi];
	assign immExt = {{(DataWidth - ImmWidth){instrWord[ImmLo]}}, instrWord[ImmLo:ImmHi]};

	assign useRs2 = opcode inside {OpAdd, OpSub, OpAnd, OpOr, OpXor, OpSlt, OpSll, OpSrl, OpFlt};
	assign readFp = opcode inside {OpFneg, OpFabs, OpFlt, OpMovfp2i};
	assign destFp = opcode inside {OpFneg, OpFabs, OpMovi2fp};

	always_comb begin
		known = 1'b1;
		execOp = ExAdd;
		case (opcode)
			OpAdd, OpAddi: execOp = ExAdd;
			OpSub: execOp = ExSub;
			OpAnd: execOp = ExAnd;
			OpOr: execOp = ExOr;
			OpXor: execOp = ExXor;
			OpSlt: execOp = ExSlt;
			OpSll: execOp = ExSll;
			OpSrl: execOp = ExSrl;
			OpFneg: execOp = ExFneg;
			OpFabs: execOp = ExFabs;
			OpFlt: execOp = ExFlt;
			OpMovi2fp, OpMovfp2i: execOp = ExMove;
			default: known = 1'b0;
		endcase
	end

	assign rdFp = readFp;
	assign rdAddr1 = rs1;
	assign rdAddr2 = rs2;

	// ====================================================================
	// Scoreboard and credits
	// ====================================================================
	assign srcBusy = readFp ? (fpBusy[rs1] || (useRs2 && fpBusy[rs2]))
		: (intBusy[rs1] || (useRs2 && intBusy[rs2]));
	assign dstBusy = destFp ? fpBusy[rd] : intBusy[rd];

	assign instrReady = (creditCnt != '0) && !(known && (srcBusy || dstBusy));
	// Unknown opcodes are taken and dropped here.
	assign spend = instrValid && instrReady && known;

	always_ff @(posedge clk) begin
		if (rst)
			creditCnt <= CreditWidth'(QueueDepth);
		else
			creditCnt <= creditCnt - CreditWidth'(spend) + CreditWidth'(creditReturn);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			intBusy <= '0;
			fpBusy <= '0;
		end else begin
			if (retireFire) begin
				if (retireFp)
					fpBusy[retireDest] <= 1'b0;
				else
					intBusy[retireDest] <= 1'b0;
			end
			if (spend) begin
				if (destFp)
					fpBusy[rd] <= 1'b1;
				else
					intBusy[rd] <= 1'b1;
			end
		end
	end

	// Issue register.
	always_ff @(posedge clk) begin
		if (rst)
			opValid <= 1'b0;
		else
			opValid <= spend;
	end

	always_ff @(posedge clk) begin
		if (spend) begin
			opExec <= execOp;
			opDest <= rd;
			opDestFp <= destFp;
			opA <= rdData1;
			opB <= isImm ? immExt : rdData2;
		end
	end

endmodule

// File: hw/opQueue.sv
module opQueue (
	input logic clk,
	input logic rst,
	input logic opValid,
	input logic [0:dlxCorePkg::ExecOpWidth-1] opExec,
	input logic [0:dlxIsaPkg::RegAddrWidth-1] opDest,
	input logic opDestFp,
	input logic [0:dlxIsaPkg::DataWidth-1] opA,
	input logic [0:dlxIsaPkg::DataWidth-1] opB,
	input logic pop,
	output logic headValid,
	output logic [0:dlxCorePkg::ExecOpWidth-1] headExec,
	output logic [0:dlxIsaPkg::RegAddrWidth-1] headDest,
	output logic headDestFp,
	output logic [0:dlxIsaPkg::DataWidth-1] headA,
	output logic [0:dlxIsaPkg::DataWidth-1] headB,
	output logic creditReturn
);

	import dlxIsaPkg::*;
	import dlxCorePkg::*;

	logic [0:ExecOpWidth-1] execMem [0:QueueDepth-1];
	logic [0:RegAddrWidth-1] destMem [0:QueueDepth-1];
	logic [0:QueueDepth-1] destFpMem;
	logic [0:DataWidth-1] aMem [0:QueueDepth-1];
	logic [0:DataWidth-1] bMem [0:QueueDepth-1];
	logic [0:QueuePtrWidth-1] wrPtr;
	logic [0:QueuePtrWidth-1] rdPtr;
	logic [0:CreditWidth-1] count;
	logic doPop;

	assign headValid = (count != '0);
	assign doPop = pop && headValid;

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			creditReturn <= 1'b0;
		end else begin
			if (opValid)
				wrPtr <= (wrPtr == QueuePtrWidth'(QueueDepth - 1)) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (rdPtr == QueuePtrWidth'(QueueDepth - 1)) ? '0 : rdPtr + 1'b1;
			count <= count + CreditWidth'(opValid) - CreditWidth'(doPop);
			// One credit back per popped entry.
			creditReturn <= doPop;
		end
	end

	always_ff @(posedge clk) begin
		if (opValid) begin
			execMem[wrPtr] <= opExec;
			destMem[wrPtr] <= opDest;
			destFpMem[wrPtr] <= opDestFp;
			aMem[wrPtr] <= opA;
			bMem[wrPtr] <= opB;
		end
	end

	assign headExec = execMem[rdPtr];
	assign headDest = destMem[rdPtr];
	assign headDestFp = destFpMem[rdPtr];
	assign headA = aMem[rdPtr];
	assign headB = bMem[rdPtr];

endmodule

// File: hw/execUnit.sv
module execUnit (
	input logic clk,
	input logic rst,
	input logic headValid,
	input logic [0:dlxCorePkg::ExecOpWidth-1] headExec,
	input logic [0:dlxIsaPkg::RegAddrWidth-1] headDest,
	input logic headDestFp,
	input logic [0:dlxIsaPkg::DataWidth-1] headA,
	input logic [0:dlxIsaPkg::DataWidth-1] headB,
	output logic pop,
	output logic retireValid,
	output logic [0:dlxIsaPkg::DataWidth-1] retireData,
	output logic [0:dlxIsaPkg::RegAddrWidth-1] retireDest,
	output logic retireFp,
	input logic retireReady
);

	import dlxIsaPkg::*;
	import dlxCorePkg::*;

	dataWord_u wordA;
	dataWord_u wordB;
	dataWord_u fpWord;
	logic [0:DataWidth-2] magA;
	logic [0:DataWidth-2] magB;
	logic bothZero;
	logic ltBit;
	logic [0:DataWidth-1] result;

	// ====================================================================
	// FP compare
	// ====================================================================
	assign wordA.raw = headA;
	assign wordB.raw = headB;
	assign magA = {wordA.fp.exponent, wordA.fp.fraction};
	assign magB = {wordB.fp.exponent, wordB.fp.fraction};
	// +0 and -0 compare equal.
	assign bothZero = (magA == '0) && (magB == '0);

	always_comb begin
		if (bothZero)
			ltBit = 1'b0;
		else if (wordA.fp.sign != wordB.fp.sign)
			ltBit = wordA.fp.sign;
		else if (wordA.fp.sign)
			ltBit = (magB < magA);
		else
			ltBit = (magA < magB);
	end

	// ====================================================================
	// Result select
	// ====================================================================
	always_comb begin
		fpWord = wordA;
		case (headExec)
			ExAdd: result = headA + headB;
			ExSub: result = headA - headB;
			ExAnd: result = headA & headB;
			ExOr: result = headA | headB;
			ExXor: result = headA ^ headB;
			ExSlt: result = {{(DataWidth - 1){1'b0}}, $signed(headA) < $signed(headB)};
			ExSll: result = headA << headB[DataWidth-ShamtWidth:DataWidth-1];
			ExSrl: result = headA >> headB[DataWidth-ShamtWidth:DataWidth-1];
			ExFneg: begin
				fpWord.fp.sign = ~wordA.fp.sign;
				result = fpWord.raw;
			end
			ExFabs: begin
				fpWord.fp.sign = 1'b0;
				result = fpWord.raw;
			end
			ExFlt: result = {{(DataWidth - 1){1'b0}}, ltBit};
			default: result = headA;
		endcase
	end

	// Retire register takes a new result when empty or draining.
	assign pop = headValid && (!retireValid || retireReady);

	always_ff @(posedge clk) begin
		if (rst)
			retireValid <= 1'b0;
		else if (pop)
			retireValid <= 1'b1;
		else if (retireReady)
			retireValid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			retireData <= result;
			retireDest <= headDest;
			retireFp <= headDestFp;
		end
	end

endmodule

// File: hw/dlxExecCore.sv
module dlxExecCore (
	input logic clk,
	input logic rst,
	input logic instrValid,
	input logic [0:dlxIsaPkg::InstrWidth-1] instrWord,
	output logic instrReady,
	output logic retireValid,
	output logic [0:dlxIsaPkg::DataWidth-1] retireData,
	output logic [0:dlxIsaPkg::RegAddrWidth-1] retireDest,
	output logic retireFp,
	input logic retireReady
);

	import dlxIsaPkg::*;
	import dlxCorePkg::*;

	logic rdFp;
	logic [0:RegAddrWidth-1] rdAddr1;
	logic [0:RegAddrWidth-1] rdAddr2;
	logic [0:DataWidth-1] rdData1;
	logic [0:DataWidth-1] rdData2;
	logic retireFire;
	logic creditReturn;
	logic opValid;
	logic [0:ExecOpWidth-1] opExec;
	logic [0:RegAddrWidth-1] opDest;
	logic opDestFp;
	logic [0:DataWidth-1] opA;
	logic [0:DataWidth-1] opB;
	logic headValid;
	logic [0:ExecOpWidth-1] headExec;
	logic [0:RegAddrWidth-1] headDest;
	logic headDestFp;
	logic [0:DataWidth-1] headA;
	logic [0:DataWidth-1] headB;
	logic pop;

	// Write back only on the retire handshake.
	assign retireFire = retireValid && retireReady;

	regFile regs (
		.clk(clk), .rst(rst),
		.wrEn(retireFire), .wrFp(retireFp), .wrAddr(retireDest), .wrData(retireData),
		.rdFp(rdFp), .rdAddr1(rdAddr1), .rdAddr2(rdAddr2),
		.rdData1(rdData1), .rdData2(rdData2)
	);

	issueUnit issue (
		.clk(clk), .rst(rst),
		.instrValid(instrValid), .instrWord(instrWord), .instrReady(instrReady),
		.rdFp(rdFp), .rdAddr1(rdAddr1), .rdAddr2(rdAddr2),
		.rdData1(rdData1), .rdData2(rdData2),
		.creditReturn(creditReturn),
		.retireFire(retireFire), .retireDest(retireDest), .retireFp(retireFp),
		.opValid(opValid), .opExec(opExec), .opDest(opDest), .opDestFp(opDestFp),
		.opA(opA), .opB(opB)
	);

	opQueue queue (
		.clk(clk), .rst(rst),
		.opValid(opValid), .opExec(opExec), .opDest(opDest), .opDestFp(opDestFp),
		.opA(opA), .opB(opB), .pop(pop),
		.headValid(headValid), .headExec(headExec), .headDest(headDest),
		.headDestFp(headDestFp), .headA(headA), .headB(headB),
		.creditReturn(creditReturn)
	);

	execUnit exec (
		.clk(clk), .rst(rst),
		.headValid(headValid), .headExec(headExec), .headDest(headDest),
		.headDestFp(headDestFp), .headA(headA), .headB(headB),
		.pop(pop), .retireValid(retireValid), .retireData(retireData),
		.retireDest(retireDest), .retireFp(retireFp), .retireReady(retireReady)
	);

endmodule

// File: tests/dlxExecCore_tb.sv
module dlxExecCore_tb;

	import dlxIsaPkg::*;
	import dlxCorePkg::*;

	// Upper bound on instructions sent over all tests for the watchdog.
	localparam int TotalInstr = 640;

	logic clk = 1'b0;
	logic rst;
	logic instrValid;
	logic [0:InstrWidth-1] instrWord;
	logic instrReady;
	logic retireValid;
	logic [0:DataWidth-1] retireData;
	logic [0:RegAddrWidth-1] retireDest;
	logic retireFp;
	logic retireReady;

	int seed = 83833;
	int errors = 0;
	int checks = 0;
	int errAtStart = 0;
	bit randomReady = 1'b0;

	// Model copies of both banks, updated in program order.
	logic [31:0] intRef [0:NumRegs-1];
	logic [31:0] fpRef [0:NumRegs-1];
	// Expected retires as {fp, dest, data}.
	logic [37:0] expQ [$];

	logic [5:0] intOps [0:8] = '{OpAdd, OpSub, OpAnd, OpOr, OpXor, OpSlt, OpSll, OpSrl, OpAddi};
	logic [31:0] fpPatterns [0:6] = '{32'h3F800000, 32'hC0200000, 32'h00000000, 32'h80000000,
		32'h3F000000, 32'hBE800000, 32'h00000001};
	logic [5:0] badOps [0:7] = '{6'h00, 6'h0A, 6'h0F, 6'h15, 6'h20, 6'h2A, 6'h3E, 6'h3F};

	dlxExecCore dut (
		.clk(clk), .rst(rst),
		.instrValid(instrValid), .instrWord(instrWord), .instrReady(instrReady),
		.retireValid(retireValid), .retireData(retireData), .retireDest(retireDest),
		.retireFp(retireFp), .retireReady(retireReady)
	);

	always #2 clk = ~clk;

	always @(negedge clk) begin
		if (randomReady)
			retireReady = $random(seed) & 1;
	end

	function automatic logic [31:0] encR(input logic [5:0] op, input int rd, input int a,
		input int b);
		return {op, 5'(a), 5'(b), 5'(rd), 11'b0};
	endfunction

	function automatic logic [31:0] encI(input logic [5:0] op, input int rd, input int a,
		input logic [15:0] imm);
		return {op, 5'(a), 5'(rd), imm};
	endfunction

	// IEEE less-than through a signed magnitude key where -0 and +0 share one key.
	function automatic logic [31:0] ieeeLess(input logic [31:0] x, input logic [31:0] y);
		dataWord_u ux;
		dataWord_u uy;
		longint kx;
		longint ky;
		ux.raw = x;
		uy.raw = y;
		kx = {ux.fp.exponent, ux.fp.fraction};
		ky = {uy.fp.exponent, uy.fp.fraction};
		if (ux.fp.sign)
			kx = -kx;
		if (uy.fp.sign)
			ky = -ky;
		return (kx < ky) ? 32'd1 : 32'd0;
	endfunction

	// ====================================================================
	// Reference model returning {known, fp, dest, data}
	// ====================================================================
	function automatic logic [38:0] refResult(input logic [31:0] w);
		logic [5:0] op;
		logic [4:0] d;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic fpDst;
		logic known;
		dataWord_u u;
		op = w[31:26];
		d = w[15:11];
		a = intRef[w[25:21]];
		b = intRef[w[20:16]];
		u.raw = fpRef[w[25:21]];
		known = 1'b1;
		fpDst = 1'b0;
		res = '0;
		case (op)
			OpAdd: res = a + b;
			OpSub: res = a - b;
			OpAnd: res = a & b;
			OpOr: res = a | b;
			OpXor: res = a ^ b;
			OpSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			OpSll: res = a << b[4:0];
			OpSrl: res = a >> b[4:0];
			OpAddi: begin
				d = w[20:16];
				res = a + {{16{w[15]}}, w[15:0]};
			end
			OpFneg, OpFabs: begin
				u.fp.sign = (op == OpFneg) ? !u.fp.sign : 1'b0;
				res = u.raw;
				fpDst = 1'b1;
			end
			OpFlt: res = ieeeLess(fpRef[w[25:21]], fpRef[w[20:16]]);
			OpMovi2fp: begin
				res = a;
				fpDst = 1'b1;
			end
			OpMovfp2i: res = u.raw;
			default: known = 1'b0;
		endcase
		return {known, fpDst, d, res};
	endfunction

	// Runs from one falling edge to another and leaves an untaken word offered.
	task automatic sendInstr(input logic [31:0] word, input int limit, output bit taken);
		logic [38:0] expVal;
		int n;
		instrValid = 1'b1;
		instrWord = word;
		taken = 1'b0;
		n = 0;
		while (!taken && n < limit) begin
			@(posedge clk);
			taken = instrReady;
			n++;
		end
		if (taken) begin
			expVal = refResult(word);
			if (expVal[38]) begin
				if (expVal[37])
					fpRef[expVal[36:32]] = expVal[31:0];
				else
					intRef[expVal[36:32]] = expVal[31:0];
				expQ.push_back(expVal[37:0]);
			end
		end
		@(negedge clk);
		if (taken)
			instrValid = 1'b0;
	endtask

	task automatic send(input logic [31:0] word);
		bit taken;
		sendInstr(word, 1000, taken);
		assert (taken) else begin
			$display("instruction %h was not accepted by %0t", word, $time);
			errors++;
		end
	endtask

	task automatic drain();
		randomReady = 1'b0;
		retireReady = 1'b1;
		while (expQ.size() != 0)
			@(negedge clk);
	endtask

	task automatic endTest(input string name);
		drain();
		$display("%s: %0d errors", name, errors - errAtStart);
		errAtStart = errors;
	endtask

	// Builds a full 32-bit constant in rd with r29..r31 as scratch.
	task automatic loadConst(input int rd, input logic [31:0] value);
		send(encR(OpXor, 31, 31, 31));
		send(encI(OpAddi, 30, 31, 16'd16));
		send(encI(OpAddi, 29, 31, value[31:16]));
		send(encR(OpSll, 29, 29, 30));
		send(encI(OpAddi, rd, 31, value[15:0]));
		send(encR(OpSll, rd, rd, 30));
		send(encR(OpSrl, rd, rd, 30));
		send(encR(OpOr, rd, rd, 29));
	endtask

	// ====================================================================
	// Comparison of each retire handshake
	// ====================================================================
	always @(posedge clk) begin
		logic [37:0] e;
		if (!rst && retireValid && retireReady) begin
			assert (expQ.size() != 0) else begin
				$display("a result retired at %0t while none was expected", $time);
				errors++;
			end
			if (expQ.size() != 0) begin
				e = expQ.pop_front();
				checks++;
				assert (retireData === e[31:0]) else begin
					$display("error at %0t: retireData = %h, expected %h", $time, retireData,
						e[31:0]);
					errors++;
				end
				assert (retireDest === e[36:32]) else begin
					$display("error at %0t: retireDest = %0d, expected %0d", $time, retireDest,
						e[36:32]);
					errors++;
				end
				assert (retireFp === e[37]) else begin
					$display("error at %0t: retireFp = %b, expected %b", $time, retireFp, e[37]);
					errors++;
				end
			end
		end
	end

	initial begin
		#((TotalInstr * 40 + 1000) * 4);
		$display("watchdog expired before the tests finished");
		$display("TB FAILED");
		$finish;
	end

	initial begin
		int i;
		int j;
		int accepted;
		bit taken;
		logic [31:0] heldWord;
		for (i = 0; i < NumRegs; i++) begin
			intRef[i] = '0;
			fpRef[i] = '0;
		end
		rst = 1'b1;
		instrValid = 1'b0;
		instrWord = '0;
		retireReady = 1'b1;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		assert (retireValid === 1'b0) else begin
			$display("error at %0t: retireValid = %b, expected 0", $time, retireValid);
			errors++;
		end
		send(encR(OpMovfp2i, 1, 5, 0));
		send(encR(OpAdd, 2, 3, 4));
		endTest("after reset");

		for (i = 1; i < NumRegs; i++)
			send(encI(OpAddi, i, 0, 16'($random(seed))));
		for (i = 0; i < 200; i++) begin
			j = $unsigned($random(seed)) % 9;
			if (intOps[j] == OpAddi)
				send(encI(OpAddi, $unsigned($random(seed)) % 32, $unsigned($random(seed)) % 32,
					16'($random(seed))));
			else
				send(encR(intOps[j], $unsigned($random(seed)) % 32, $unsigned($random(seed)) % 32,
					$unsigned($random(seed)) % 32));
		end
		endTest("integer operations");

		for (i = 0; i < 7; i++) begin
			loadConst(i + 1, fpPatterns[i]);
			send(encR(OpMovi2fp, i + 1, i + 1, 0));
		end
		for (i = 1; i <= 7; i++) begin
			send(encR(OpFneg, i + 8, i, 0));
			send(encR(OpFabs, i + 16, i, 0));
			send(encR(OpMovfp2i, i + 8, i, 0));
			for (j = 1; j <= 7; j++)
				send(encR(OpFlt, 20, i, j));
		end
		endTest("fp operations");

		for (i = 0; i < 40; i++)
			send(encR(intOps[i % 8], 5, 5, $unsigned($random(seed)) % 32));
		for (i = 0; i < 20; i++) begin
			send(encR(OpMovi2fp, 3, 5, 0));
			send(encR(OpFneg, 3, 3, 0));
			send(encR(OpFabs, 4, 3, 0));
			send(encR(OpFlt, 5, 4, 3));
		end
		endTest("dependent chains");

		retireReady = 1'b0;
		accepted = 0;
		taken = 1'b1;
		for (i = 0; taken; i++) begin
			heldWord = encI(OpAddi, 8 + i, 0, 16'(i + 1));
			sendInstr(heldWord, 20, taken);
			if (taken)
				accepted++;
		end
		assert (accepted == QueueDepth + 1) else begin
			$display("error at %0t: accepted = %0d, expected %0d", $time, accepted,
				QueueDepth + 1);
			errors++;
		end
		randomReady = 1'b1;
		send(heldWord);
		for (i = 0; i < 60; i++)
			send(encR(intOps[i % 8], $unsigned($random(seed)) % 32, $unsigned($random(seed)) % 32,
				$unsigned($random(seed)) % 32));
		endTest("back-pressure");

		for (i = 0; i < 8; i++) begin
			sendInstr({badOps[i], 26'($random(seed))}, 1000, taken);
			assert (taken) else begin
				$display("an unknown opcode was not accepted at %0t", $time);
				errors++;
			end
		end
		for (i = 0; i < NumRegs; i++)
			send(encR(OpOr, i, i, i));
		for (i = 0; i < NumRegs; i++)
			send(encR(OpMovfp2i, 0, i, 0));
		endTest("unknown opcodes");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: dlxExecCore.f
hw/dlxIsaPkg.sv
hw/dlxCorePkg.sv
hw/regFile.sv
hw/issueUnit.sv
hw/opQueue.sv
hw/execUnit.sv
hw/dlxExecCore.sv
tests/dlxExecCore_tb.sv

// File: Bender.yml
package:
  name: dlx_exec_core

sources:
  - files:
      - hw/dlxIsaPkg.sv
      - hw/dlxCorePkg.sv
      - hw/regFile.sv
      - hw/issueUnit.sv
      - hw/opQueue.sv
      - hw/execUnit.sv
      - hw/dlxExecCore.sv
  - target: test
    files:
      - tests/dlxExecCore_tb.sv
